// File: logic/ecpu_op_pkg.sv
/* eCPU op word layout, register-number field and
   the op/strobe bus struct seen by the glue blocks */

`default_nettype none

package ecpu_op_pkg;

    // raw 16-bit op word from the eCPU
    typedef logic [15:0] op_t;

    // one-hot opcode bits, register ops
    localparam int unsigned op_set_ctrl    = 0;
    localparam int unsigned op_get_status  = 1;
    localparam int unsigned op_get_adc_ctr = 2;
    localparam int unsigned op_get_cpu_ctr = 3;
    localparam int unsigned op_get_srq     = 4;
    // one-hot opcode bits, event ops
    localparam int unsigned op_ctr_clr     = 5;
    localparam int unsigned op_ctr_ena     = 8;
    localparam int unsigned op_ctr_dis     = 9;

    // register number sits in op[7:6]
    localparam int unsigned reg_no_lsb = 6;
    localparam int unsigned reg_no_msb = 7;

    typedef logic [1:0] reg_no_t;

    // op word, top of stack and the one-cycle strobes
    typedef struct packed {
        op_t         op;
        logic [31:0] tos;
        logic        rd_reg;
        logic        wr_reg;
        logic        wr_evt;
    } cpu_bus_t;

    function automatic reg_no_t reg_no_of(op_t op);
        return op[reg_no_msb:reg_no_lsb];
    endfunction

endpackage

`default_nettype wire

// File: logic/kiwi_ctrl_pkg.sv
/* control register layout, serial-select codes,
   serial pin triple, status word and counter word */

`default_nettype none

package kiwi_ctrl_pkg;

    // which serial device gets the bit-banged triple
    typedef enum logic [1:0] {
        ser_attn = 2'd0,
        ser_gps  = 2'd1,
        ser_dna  = 2'd2
    } ser_sel_t;

    // global control register, 14 bits, msb first
    typedef struct packed {
        logic [3:0] reserved;
        logic       eeprom_wp;
        logic       snd_intr;
        logic       cmd_ready;
        logic       osc_dis;
        logic       sten;
        logic       ser_data;
        logic       ser_clk;
        logic       ser_le_csn;
        ser_sel_t   ser_sel;
    } ctrl_t;

    // latch/clock/data for one serial lane
    typedef struct packed {
        logic le_csn;
        logic clk;
        logic data;
    } ser_pins_t;

    // status word as read by the eCPU
    typedef struct packed {
        logic       rx_ovfl;
        logic [2:0] zero;
        logic [3:0] fpga_ver;
        logic [2:0] user_zero;
        logic       dna_bit;
        logic [3:0] fpga_id;
    } status_t;

    // cycle and ADC counter word
    typedef logic [31:0] ctr_t;

endpackage

`default_nettype wire

// File: logic/ctrl_reg.sv
/* global control register and the pin levels decoded from it */

`timescale 1ns/1ps
`default_nettype none

module ctrl_reg (
    input  wire                   cpu_clk,
    input  wire                   rx_orst,
    input  ecpu_op_pkg::cpu_bus_t bus,
    input  wire                   ext_intr,
    output kiwi_ctrl_pkg::ctrl_t  ctrl,
    output logic                  adc_clken,
    output logic                  adc_stenl,
    output logic                  ewp,
    output logic                  cmd_ready,
    output logic                  snd_intr
);

    import ecpu_op_pkg::*;
    import kiwi_ctrl_pkg::*;

    localparam int unsigned ctrl_w = $bits(ctrl_t);

    // set-control write loads the low bits of tos
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ctrl <= '0;
        else if (bus.wr_reg && bus.op[op_set_ctrl])
            ctrl <= ctrl_t'(bus.tos[ctrl_w-1:0]);
    end

    //////////////////////////////
    // pin decode
    //////////////////////////////

    // oscillator and self test are active-low disables
    assign adc_clken = ~ctrl.osc_dis;
    assign adc_stenl = ~ctrl.sten;
    assign ewp       = ctrl.eeprom_wp;
    assign cmd_ready = ctrl.cmd_ready;
    // sound irq also raised by the extension side
    assign snd_intr  = ctrl.snd_intr | ext_intr;

endmodule

`default_nettype wire

// File: logic/ser_port_steer.sv
/* serial latch/clock/data steering to attenuator, GPS and device-ID,
   device-ID read and shift level-to-pulse conversion */

`timescale 1ns/1ps
`default_nettype none

module ser_port_steer (
    input  wire                     cpu_clk,
    input  wire                     rx_orst,
    input  kiwi_ctrl_pkg::ctrl_t    ctrl,
    output kiwi_ctrl_pkg::ser_pins_t attn_pins,
    output kiwi_ctrl_pkg::ser_pins_t gps_pins,
    output logic                    dna_read_pulse,
    output logic                    dna_shift_pulse
);

    import kiwi_ctrl_pkg::*;

    // rising-edge pattern in a 2-stage history
    localparam logic [1:0] rise = 2'b01;

    ser_pins_t  ctrl_pins;
    ser_pins_t  dna_pins;
    logic [1:0] dna_rd_hist;
    logic [1:0] dna_sf_hist;

    // triple as written by the CPU
    assign ctrl_pins = '{le_csn: ctrl.ser_le_csn, clk: ctrl.ser_clk, data: ctrl.ser_data};

    //////////////////////////////
    // lane steering
    //////////////////////////////

    // unselected lanes held at zero
    assign attn_pins = (ctrl.ser_sel == ser_attn) ? ctrl_pins : '0;
    assign gps_pins  = (ctrl.ser_sel == ser_gps)  ? ctrl_pins : '0;
    assign dna_pins  = (ctrl.ser_sel == ser_dna)  ? ctrl_pins : '0;

    //////////////////////////////
    // device-ID pulses
    //////////////////////////////

    // latch doubles as read, data doubles as shift, both qualified by clk
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            dna_rd_hist <= '0;
            dna_sf_hist <= '0;
        end
        else
        begin
            dna_rd_hist <= {dna_rd_hist[0], dna_pins.le_csn & dna_pins.clk};
            dna_sf_hist <= {dna_sf_hist[0], dna_pins.data & dna_pins.clk};
        end
    end

    // one cycle per rise
    assign dna_read_pulse  = (dna_rd_hist == rise);
    assign dna_shift_pulse = (dna_sf_hist == rise);

endmodule

`default_nettype wire

// File: logic/cycle_counters.sv
/* two CPU cycle counters with shared clear and enable flag */

`timescale 1ns/1ps
`default_nettype none

module cycle_counters (
    input  wire                   cpu_clk,
    input  wire                   rx_orst,
    input  ecpu_op_pkg::cpu_bus_t bus,
    output kiwi_ctrl_pkg::ctr_t   ctr0,
    output kiwi_ctrl_pkg::ctr_t   ctr1
);

    import ecpu_op_pkg::*;

    logic ctr_clr;
    logic ctr_ena;

    // event strobes
    assign ctr_clr = bus.wr_evt & bus.op[op_ctr_clr];

    // ctr0 free-running, ctr1 only while enabled
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst || ctr_clr)
        begin
            ctr0 <= '0;
            ctr1 <= '0;
        end
        else
        begin
            ctr0 <= ctr0 + 1'b1;
            if (ctr_ena)
                ctr1 <= ctr1 + 1'b1;
        end
    end

    // enable flag, seen by ctr1 from the following edge
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ctr_ena <= 1'b0;
        else if (bus.wr_evt && bus.op[op_ctr_ena])
            ctr_ena <= 1'b1;
        else if (bus.wr_evt && bus.op[op_ctr_dis])
            ctr_ena <= 1'b0;
    end

endmodule

`default_nettype wire

// File: logic/event_flags.sv
/* sticky ADC overflow flag and host service-request capture */

`timescale 1ns/1ps
`default_nettype none

module event_flags (
    input  wire                   cpu_clk,
    input  wire                   rx_orst,
    input  ecpu_op_pkg::cpu_bus_t bus,
    input  wire                   host_srq,
    input  wire                   rx_ovfl,
    input  wire                   ovfl_clr,
    output logic                  ovfl_sticky,
    output logic                  srq_ser
);

    import ecpu_op_pkg::*;

    logic srq_rd;
    logic srq_noted;

    assign srq_rd = bus.rd_reg & bus.op[op_get_srq];

    //////////////////////////////
    // overflow
    //////////////////////////////

    // clear reloads from the live input so a same-cycle overflow is kept
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
            ovfl_sticky <= 1'b0;
        else if (ovfl_clr)
            ovfl_sticky <= rx_ovfl;
        else
            ovfl_sticky <= ovfl_sticky | rx_ovfl;
    end

    //////////////////////////////
    // service request
    //////////////////////////////

    // noted collects requests between reads
    // read hands noted to the serial bit
    always_ff @(posedge cpu_clk)
    begin
        if (rx_orst)
        begin
            srq_noted <= 1'b0;
            srq_ser   <= 1'b0;
        end
        else if (srq_rd)
        begin
            srq_noted <= host_srq;
            srq_ser   <= srq_noted;
        end
        else
            srq_noted <= srq_noted | host_srq;
    end

endmodule

`default_nettype wire

// File: logic/readback_mux.sv
/* status word assembly and the eCPU parallel read-back mux */

`timescale 1ns/1ps
`default_nettype none

module readback_mux #(
    parameter logic [3:0] FPGA_VER = 4'd1,
    parameter logic [3:0] FPGA_ID  = 4'd0
) (
    input  ecpu_op_pkg::cpu_bus_t bus,
    input  kiwi_ctrl_pkg::ctr_t   ctr0,
    input  kiwi_ctrl_pkg::ctr_t   ctr1,
    input  kiwi_ctrl_pkg::ctr_t   adc_count,
    input  wire                   ovfl_sticky,
    input  wire                   dna_data,
    input  wire  [15:0]           host_dout,
    output logic [15:0]           par
);

    import ecpu_op_pkg::*;
    import kiwi_ctrl_pkg::*;

    status_t status;
    reg_no_t reg_no;
    logic    rd_cpu_ctr;
    logic    rd_adc_ctr;
    logic    rd_status;

    // unused status positions read zero
    assign status = '{
        rx_ovfl:   ovfl_sticky,
        zero:      '0,
        fpga_ver:  FPGA_VER,
        user_zero: '0,
        dna_bit:   dna_data,
        fpga_id:   FPGA_ID
    };

    assign reg_no     = reg_no_of(bus.op);
    assign rd_cpu_ctr = bus.rd_reg & bus.op[op_get_cpu_ctr];
    assign rd_adc_ctr = bus.rd_reg & bus.op[op_get_adc_ctr];
    assign rd_status  = bus.rd_reg & bus.op[op_get_status];

    //////////////////////////////
    // read-back priority
    //////////////////////////////

    always_comb
    begin
        // byte n of both cycle counters side by side
        if (rd_cpu_ctr)
            par = {ctr1[{reg_no, 3'b000} +: 8], ctr0[{reg_no, 3'b000} +: 8]};
        else if (rd_adc_ctr && reg_no == 2'd0)
            par = adc_count[15:0];
        else if (rd_adc_ctr && reg_no == 2'd1)
            par = adc_count[31:16];
        else if (rd_status)
            par = status;
        else
            // host data when nothing else claims the bus
            par = host_dout;
    end

endmodule

`default_nettype wire

// File: logic/kiwi_ctrl_top.sv
/* CPU-side glue top level, control register, serial steering,
   cycle counters, event flags and read-back mux */

`timescale 1ns/1ps
`default_nettype none

module kiwi_ctrl_top #(
    parameter logic [3:0] FPGA_VER = 4'd1,
    parameter logic [3:0] FPGA_ID  = 4'd0
) (
    input  wire                      cpu_clk,
    input  wire                      rx_orst,
    input  ecpu_op_pkg::cpu_bus_t    bus,
    input  wire                      host_srq,
    input  wire                      rx_ovfl,
    input  wire                      ovfl_clr,
    input  wire  [15:0]              host_dout,
    input  kiwi_ctrl_pkg::ctr_t      adc_count,
    input  wire                      dna_data,
    output logic [15:0]              par,
    output logic                     srq_ser,
    output kiwi_ctrl_pkg::ser_pins_t attn_pins,
    output kiwi_ctrl_pkg::ser_pins_t gps_pins,
    output logic                     dna_read_pulse,
    output logic                     dna_shift_pulse,
    output logic                     adc_clken,
    output logic                     adc_stenl,
    output logic                     ewp,
    output logic                     cmd_ready,
    output logic                     snd_intr
);

    import kiwi_ctrl_pkg::*;

    ctrl_t ctrl;
    ctr_t  ctr0;
    ctr_t  ctr1;
    logic  ovfl_sticky;

    //////////////////////////////
    // control and serial
    //////////////////////////////

    // no extension block, so no external sound irq
    ctrl_reg u_ctrl (
        .cpu_clk   (cpu_clk),
        .rx_orst   (rx_orst),
        .bus       (bus),
        .ext_intr  (1'b0),
        .ctrl      (ctrl),
        .adc_clken (adc_clken),
        .adc_stenl (adc_stenl),
        .ewp       (ewp),
        .cmd_ready (cmd_ready),
        .snd_intr  (snd_intr)
    );

    ser_port_steer u_steer (
        .cpu_clk         (cpu_clk),
        .rx_orst         (rx_orst),
        .ctrl            (ctrl),
        .attn_pins       (attn_pins),
        .gps_pins        (gps_pins),
        .dna_read_pulse  (dna_read_pulse),
        .dna_shift_pulse (dna_shift_pulse)
    );

    //////////////////////////////
    // counters, flags, read-back
    //////////////////////////////

    cycle_counters u_ctr (
        .cpu_clk (cpu_clk),
        .rx_orst (rx_orst),
        .bus     (bus),
        .ctr0    (ctr0),
        .ctr1    (ctr1)
    );

    event_flags u_flags (
        .cpu_clk     (cpu_clk),
        .rx_orst     (rx_orst),
        .bus         (bus),
        .host_srq    (host_srq),
        .rx_ovfl     (rx_ovfl),
        .ovfl_clr    (ovfl_clr),
        .ovfl_sticky (ovfl_sticky),
        .srq_ser     (srq_ser)
    );

    readback_mux #(
        .FPGA_VER (FPGA_VER),
        .FPGA_ID  (FPGA_ID)
    ) u_rdbk (
        .bus         (bus),
        .ctr0        (ctr0),
        .ctr1        (ctr1),
        .adc_count   (adc_count),
        .ovfl_sticky (ovfl_sticky),
        .dna_data    (dna_data),
        .host_dout   (host_dout),
        .par         (par)
    );

endmodule

`default_nettype wire

// File: verif/kiwi_ctrl_sva.sv
/* concurrent checks on the glue top level, device-ID pulse width,
   unselected serial lanes and read-back value while idle */

`timescale 1ns/1ps
`default_nettype none

module kiwi_ctrl_sva (
    input wire                      cpu_clk,
    input wire                      rx_orst,
    input ecpu_op_pkg::cpu_bus_t    bus,
    input wire [15:0]               host_dout,
    input wire [15:0]               par,
    input kiwi_ctrl_pkg::ctrl_t     ctrl,
    input kiwi_ctrl_pkg::ser_pins_t attn_pins,
    input kiwi_ctrl_pkg::ser_pins_t gps_pins,
    input wire                      dna_read_pulse,
    input wire                      dna_shift_pulse
);

    import kiwi_ctrl_pkg::*;

    // number of failed checks
    int unsigned fail_cnt = 0;

    // level-to-pulse gives single cycles only
    dna_read_width: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        dna_read_pulse |=> !dna_read_pulse)
    else
    begin
        fail_cnt++;
        $error("device-ID read pulse held for more than one cycle");
    end

    dna_shift_width: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        dna_shift_pulse |=> !dna_shift_pulse)
    else
    begin
        fail_cnt++;
        $error("device-ID shift pulse held for more than one cycle");
    end

    // lanes not selected stay quiet
    idle_lanes_zero: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        (ctrl.ser_sel == ser_attn || attn_pins == '0) &&
        (ctrl.ser_sel == ser_gps || gps_pins == '0))
    else
    begin
        fail_cnt++;
        $error("unselected serial lane not zero");
    end

    // host data owns par outside reads
    par_idle_host: assert property (@(posedge cpu_clk) disable iff (rx_orst)
        !bus.rd_reg |-> (par == host_dout))
    else
    begin
        fail_cnt++;
        $error("par differs from host_dout with rd_reg low");
    end

endmodule

bind kiwi_ctrl_top kiwi_ctrl_sva u_sva (
    .cpu_clk         (cpu_clk),
    .rx_orst         (rx_orst),
    .bus             (bus),
    .host_dout       (host_dout),
    .par             (par),
    .ctrl            (ctrl),
    .attn_pins       (attn_pins),
    .gps_pins        (gps_pins),
    .dna_read_pulse  (dna_read_pulse),
    .dna_shift_pulse (dna_shift_pulse)
);

`default_nettype wire

// File: verif/tb_kiwi_ctrl.sv
/* CPU-side glue testbench with clock, reset, file-driven
   command stream, typed compare tasks and summary */

`timescale 1ns/1ps
`default_nettype none

module tb_kiwi_ctrl;

    import ecpu_op_pkg::*;
    import kiwi_ctrl_pkg::*;

    localparam int unsigned stim_depth    = 256;
    localparam int unsigned pulse_window  = 4;
    localparam int unsigned reset_timeout = 4;
    localparam ctr_t        adc_value     = 32'hC0DE_5A17;
    localparam logic [3:0]  ver_code      = 4'd2;
    localparam logic [3:0]  id_code       = 4'd6;

    logic        cpu_clk;
    logic        rx_orst;
    cpu_bus_t    bus;
    logic        host_srq;
    logic        rx_ovfl;
    logic        ovfl_clr;
    logic [15:0] host_dout;
    ctr_t        adc_count;
    logic        dna_data;
    logic [15:0] par;
    logic        srq_ser;
    ser_pins_t   attn_pins;
    ser_pins_t   gps_pins;
    logic        dna_read_pulse;
    logic        dna_shift_pulse;
    logic        adc_clken;
    logic        adc_stenl;
    logic        ewp;
    logic        cmd_ready;
    logic        snd_intr;

    // four words per command, kind then a, b and expected
    logic [31:0] stim [0:stim_depth-1];
    int unsigned errors;
    int unsigned checks;

    kiwi_ctrl_top #(
        .FPGA_VER (ver_code),
        .FPGA_ID  (id_code)
    ) uut (
        .cpu_clk         (cpu_clk),
        .rx_orst         (rx_orst),
        .bus             (bus),
        .host_srq        (host_srq),
        .rx_ovfl         (rx_ovfl),
        .ovfl_clr        (ovfl_clr),
        .host_dout       (host_dout),
        .adc_count       (adc_count),
        .dna_data        (dna_data),
        .par             (par),
        .srq_ser         (srq_ser),
        .attn_pins       (attn_pins),
        .gps_pins        (gps_pins),
        .dna_read_pulse  (dna_read_pulse),
        .dna_shift_pulse (dna_shift_pulse),
        .adc_clken       (adc_clken),
        .adc_stenl       (adc_stenl),
        .ewp             (ewp),
        .cmd_ready       (cmd_ready),
        .snd_intr        (snd_intr)
    );

    // 8 ns cpu clock
    always #4 cpu_clk = ~cpu_clk;

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_par(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_ctrl(input ctrl_t exp, input ctrl_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR ctrl expected %h actual %h", exp, act);
        end
    endtask

    task automatic check_pins(input string name, input ser_pins_t exp, input ser_pins_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(input status_t exp, input status_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERR status expected %h actual %h (rx_ovfl %h/%h dna_bit %h/%h)",
                     exp, act, exp.rx_ovfl, act.rx_ovfl, exp.dna_bit, act.dna_bit);
        end
    endtask

    task automatic check_count(input string name, input int unsigned exp, input int unsigned act);
        checks++;
        if (act != exp)
        begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // pin levels and lanes as the control fields dictate
    task automatic check_ctrl_pins(input ctrl_t exp);
        ser_pins_t lane;
        ser_pins_t quiet;
        lane  = '{le_csn: exp.ser_le_csn, clk: exp.ser_clk, data: exp.ser_data};
        quiet = '{le_csn: 1'b0, clk: 1'b0, data: 1'b0};
        check_ctrl(exp, uut.ctrl);
        check_bit("adc_clken", ~exp.osc_dis, adc_clken);
        check_bit("adc_stenl", ~exp.sten, adc_stenl);
        check_bit("ewp", exp.eeprom_wp, ewp);
        check_bit("cmd_ready", exp.cmd_ready, cmd_ready);
        check_bit("snd_intr", exp.snd_intr, snd_intr);
        check_pins("attn_pins", (exp.ser_sel == ser_attn) ? lane : quiet, attn_pins);
        check_pins("gps_pins", (exp.ser_sel == ser_gps) ? lane : quiet, gps_pins);
        check_pins("dna_pins", (exp.ser_sel == ser_dna) ? lane : quiet, uut.u_steer.dna_pins);
    endtask

    //////////////////////////////
    // bus and pin drivers
    //////////////////////////////

    task automatic put_bus(input cpu_bus_t b);
        @(posedge cpu_clk);
        bus <= b;
    endtask

    // low nibble read pulses, high nibble shift pulses
    task automatic count_dna_pulses(input logic [7:0] exp_cnt);
        int unsigned rd_cnt;
        int unsigned sf_cnt;
        int unsigned cyc;
        rd_cnt = 0;
        sf_cnt = 0;
        for (cyc = 0; cyc < pulse_window; cyc++)
        begin
            @(posedge cpu_clk);
            @(negedge cpu_clk);
            if (dna_read_pulse)
                rd_cnt++;
            if (dna_shift_pulse)
                sf_cnt++;
        end
        check_count("dna_read_pulse count", 32'(exp_cnt[3:0]), rd_cnt);
        check_count("dna_shift_pulse count", 32'(exp_cnt[7:4]), sf_cnt);
    endtask

    task automatic write_ctrl(input logic [31:0] tos, input logic [7:0] pulses, input ctrl_t exp);
        cpu_bus_t b;
        b = '0;
        b.op[op_set_ctrl] = 1'b1;
        b.tos = tos;
        b.wr_reg = 1'b1;
        put_bus(b);
        b = '0;
        put_bus(b);
        @(negedge cpu_clk);
        check_ctrl_pins(exp);
        count_dna_pulses(pulses);
    endtask

    task automatic post_event(input op_t op, input int unsigned idle_cycles);
        cpu_bus_t    b;
        int unsigned n;
        b = '0;
        b.op = op;
        b.wr_evt = 1'b1;
        put_bus(b);
        b = '0;
        put_bus(b);
        for (n = 0; n < idle_cycles; n++)
            @(posedge cpu_clk);
    endtask

    task automatic read_reg(input op_t op, input logic [15:0] dout, input logic [15:0] exp);
        cpu_bus_t b;
        b = '0;
        b.op = op;
        b.rd_reg = 1'b1;
        @(posedge cpu_clk);
        bus <= b;
        host_dout <= dout;
        // par is combinational so look mid-cycle
        @(negedge cpu_clk);
        if (op[op_get_status] && !op[op_get_cpu_ctr] && !op[op_get_adc_ctr])
            check_status(status_t'(exp), status_t'(par));
        else
            check_par("par", exp, par);
        b = '0;
        put_bus(b);
    endtask

    // host request level rides along with the get-SRQ read
    task automatic srq_read(input logic srq_level, input logic exp);
        cpu_bus_t b;
        b = '0;
        b.op[op_get_srq] = 1'b1;
        b.rd_reg = 1'b1;
        @(posedge cpu_clk);
        bus <= b;
        host_srq <= srq_level;
        b = '0;
        @(posedge cpu_clk);
        bus <= b;
        host_srq <= 1'b0;
        @(negedge cpu_clk);
        check_bit("srq_ser", exp, srq_ser);
    endtask

    // bit 0 overflow, bit 1 clear
    task automatic pulse_ovfl(input logic [1:0] sel);
        @(posedge cpu_clk);
        rx_ovfl <= sel[0];
        ovfl_clr <= sel[1];
        @(posedge cpu_clk);
        rx_ovfl <= 1'b0;
        ovfl_clr <= 1'b0;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        int unsigned idx;
        int unsigned cyc;
        logic [31:0] kind;
        cpu_clk   = 1'b0;
        rx_orst   = 1'b1;
        bus       = '0;
        host_srq  = 1'b0;
        rx_ovfl   = 1'b0;
        ovfl_clr  = 1'b0;
        host_dout = '0;
        adc_count = adc_value;
        dna_data  = 1'b1;
        errors    = 0;
        checks    = 0;
        for (idx = 0; idx < stim_depth; idx++)
            stim[idx] = '0;
        $readmemh("verif/kiwi_ctrl_stimulus.txt", stim);

        // 3 cycles of reset
        for (cyc = 0; cyc < 3; cyc++)
            @(posedge cpu_clk);
        rx_orst <= 1'b0;
        @(negedge cpu_clk);
        cyc = 0;
        while (adc_clken !== 1'b1 && cyc < reset_timeout)
        begin
            @(negedge cpu_clk);
            cyc++;
        end
        if (adc_clken !== 1'b1)
        begin
            errors++;
            $display("timeout: adc_clken did not come up after reset");
        end
        check_ctrl_pins(ctrl_t'(0));
        check_bit("srq_ser", 1'b0, srq_ser);

        if (stim[0] == 32'd0)
        begin
            errors++;
            $display("stimulus file is missing or holds no commands");
        end
        for (idx = 0; idx + 3 < stim_depth; idx += 4)
        begin
            kind = stim[idx];
            if (kind == 32'd0)
                break;
            case (kind)
                32'd1: write_ctrl(stim[idx+1], stim[idx+2][7:0], ctrl_t'(stim[idx+3][13:0]));
                32'd2: post_event(stim[idx+1][15:0], stim[idx+2]);
                32'd3: read_reg(stim[idx+1][15:0], stim[idx+2][15:0], stim[idx+3][15:0]);
                32'd4: srq_read(stim[idx+1][0], stim[idx+3][0]);
                32'd5: pulse_ovfl(stim[idx+1][1:0]);
                default:
                begin
                    errors++;
                    $display("unknown command kind %0h in stimulus entry %0d", kind, idx / 4);
                end
            endcase
        end

        errors += uut.u_sva.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, uut.u_sva.fail_cnt);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/kiwi_ctrl_stimulus.txt
// columns (hex): kind a b expected; kind 1 write ctrl (a tos, b shift/read pulse nibbles)
// 2 event (a op, b idle cycles), 3 read (a op, b host_dout), 4 srq (a host_srq), 5 ovfl, 0 end
1 FFFFC3E0 00 03E0
1 00003C00 00 3C00
3 0002 FFFF 0216
1 0000001C 00 001C
1 0000001D 00 001D
1 0000001E 11 001E
1 0000001F 00 001F
1 00000002 00 0002
1 0000000E 01 000E
1 0000001A 10 001A
2 0020 5 0
3 0008 FFFF 0006
2 0100 3 0
3 0008 FFFF 040D
2 0200 0 0
3 0008 FFFF 0711
3 0048 FFFF 0000
3 0004 1234 5A17
3 0044 1234 C0DE
3 0084 1234 1234
3 00C4 BEEF BEEF
5 1 0 0
3 0002 0000 8216
3 0002 0000 8216
5 2 0 0
3 0002 0000 0216
4 0 0 0
4 1 0 0
4 0 0 1
4 0 0 0
0 0 0 0

// File: sim.f
logic/ecpu_op_pkg.sv
logic/kiwi_ctrl_pkg.sv
logic/ctrl_reg.sv
logic/ser_port_steer.sv
logic/cycle_counters.sv
logic/event_flags.sv
logic/readback_mux.sv
logic/kiwi_ctrl_top.sv
verif/kiwi_ctrl_sva.sv
verif/tb_kiwi_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator from sim.f, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_kiwi_ctrl \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "build or simulation returned an error, see build.log and sim.log"

grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
